//--- hdl/dram_scrub_pkg.sv
// ------------------------------
// DRAM scrub shared definitions
// Widths, register map, control word fields, ID words
// ------------------------------
package dram_scrub_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int ADDR_W     = 64;
   // One data beat is 512 bits
   localparam int BEAT_BYTES = 64;
   localparam int APB_ADDR_W = 8;

   // ------------------------------
   // Register map
   // ------------------------------
   // Control word, read/write
   localparam logic [7:0] REG_CTL0    = 8'h00;
   // Status word, read only
   localparam logic [7:0] REG_STATUS0 = 8'h04;

   // ------------------------------
   // Control word fields
   // ------------------------------
   // Per-channel scrub enables
   localparam int CTL_EN_A_BIT    = 0;
   localparam int CTL_EN_B_BIT    = 1;

   // Debug readout of the scrub address on the ID outputs
   localparam int CTL_DBG_EN_BIT  = 31;
   // 3-bit channel select, only 1 picks channel B
   localparam int CTL_DBG_SEL_LSB = 28;

   // ------------------------------
   // ID words
   // ------------------------------
   // Shown on id0/id1 while debug readout is off
   localparam logic [31:0] CL_ID0_VAL = 32'hF000_1D0F;
   localparam logic [31:0] CL_ID1_VAL = 32'h1D51_FEDD;

endpackage

//--- hdl/core_rst_sync.sv
// ------------------------------
// Core reset synchronizer
// ------------------------------
`timescale 1ns/10ps

module core_rst_sync
(
   input  logic clk,
   input  logic sync_rst_n,
   output logic core_rst_n
);

   logic [3:0] rst_pipe;
   logic       pipe_rst_n;
   logic       pre_core_rst_n;

   // Plain four-stage pipe, eases placement of the reset source
   always_ff @(posedge clk)
   begin
      rst_pipe <= {rst_pipe[2:0], sync_rst_n};
   end

   assign pipe_rst_n = rst_pipe[3];

   // Asserts as soon as the pipe output drops, releases two edges later
   always_ff @(posedge clk or negedge pipe_rst_n)
   begin
      if (!pipe_rst_n)
      begin
         pre_core_rst_n <= 1'b0;
         core_rst_n     <= 1'b0;
      end
      else
      begin
         pre_core_rst_n <= 1'b1;
         core_rst_n     <= pre_core_rst_n;
      end
   end

endmodule

//--- hdl/scrub_cfg_regs.sv
// ------------------------------
// Scrub configuration registers
// APB slave for the control word and status, plus FLR acknowledge
// ------------------------------
`timescale 1ns/10ps

module scrub_cfg_regs
(
   input  logic                                clk,
   input  logic                                core_rst_n,

   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [dram_scrub_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [31:0]                         pwdata,
   output logic                                pready,
   output logic [31:0]                         prdata,
   output logic                                pslverr,

   input  logic [31:0]                         status0,

   input  logic                                flr_assert,
   output logic                                flr_done,

   output logic                                scrub_en_a,
   output logic                                scrub_en_b,
   output logic                                dbg_en,
   output logic [2:0]                          dbg_sel
);

   import dram_scrub_pkg::*;

   logic [31:0] ctl0;
   logic        access;
   logic        hit_ctl0;
   logic        hit_status0;
   logic        flr_assert_q;

   // ------------------------------
   // APB decode
   // ------------------------------
   assign access      = psel && penable;
   assign hit_ctl0    = (paddr == REG_CTL0);
   assign hit_status0 = (paddr == REG_STATUS0);

   // No wait states
   assign pready  = access;
   assign pslverr = access && !(hit_ctl0 || hit_status0);

   always_comb
   begin
      prdata = 32'd0;
      if (access && !pwrite)
      begin
         if (hit_ctl0)
            prdata = ctl0;
         else if (hit_status0)
            prdata = status0;
      end
   end

   // Control word, updated on the edge that ends the access phase
   always_ff @(posedge clk or negedge core_rst_n)
   begin
      if (!core_rst_n)
         ctl0 <= 32'd0;
      else if (access && pwrite && hit_ctl0)
         ctl0 <= pwdata;
   end

   // Field slices
   assign scrub_en_a = ctl0[CTL_EN_A_BIT];
   assign scrub_en_b = ctl0[CTL_EN_B_BIT];
   assign dbg_en     = ctl0[CTL_DBG_EN_BIT];
   assign dbg_sel    = ctl0[CTL_DBG_SEL_LSB +: 3];

   // ------------------------------
   // FLR acknowledge
   // ------------------------------
   // Toggles while the request is held, so a one-cycle request gives one pulse
   always_ff @(posedge clk or negedge core_rst_n)
   begin
      if (!core_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

//--- hdl/ddr_scrubber.sv
// ------------------------------
// DDR scrubber, one channel
// Walks the memory in bursts and issues one write request per burst
// ------------------------------
`timescale 1ns/10ps

module ddr_scrubber
#(
   parameter logic [dram_scrub_pkg::ADDR_W-1:0] SCRB_MAX_ADDR         = 'h1FFF,
   parameter int                                SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                              clk,
   input  logic                              core_rst_n,

   input  logic                              scrub_en,

   // Write request stream
   input  logic                              wr_ready,
   output logic                              wr_valid,
   output logic [dram_scrub_pkg::ADDR_W-1:0] wr_addr,

   // Progress for the status block
   output logic [dram_scrub_pkg::ADDR_W-1:0] scrub_addr,
   output logic                              scrub_done
);

   import dram_scrub_pkg::*;

   // Address step covered by one burst
   localparam logic [ADDR_W-1:0] BURST_BYTES =
      ADDR_W'((SCRB_BURST_LEN_MINUS1 + 1) * BEAT_BYTES);

   logic              accept;
   logic [ADDR_W-1:0] next_addr;

   assign accept    = wr_valid && wr_ready;
   assign next_addr = scrub_addr + BURST_BYTES;

   // Request address only moves on acceptance, so it holds while stalled
   assign wr_addr = scrub_addr;

   // ------------------------------
   // Walker
   // ------------------------------
   always_ff @(posedge clk or negedge core_rst_n)
   begin
      if (!core_rst_n)
      begin
         scrub_addr <= '0;
         scrub_done <= 1'b0;
         wr_valid   <= 1'b0;
      end
      else if (!scrub_en)
      begin
         // Rearm for the next enable
         scrub_addr <= '0;
         scrub_done <= 1'b0;
         wr_valid   <= 1'b0;
      end
      else if (accept)
      begin
         scrub_addr <= next_addr;
         if (next_addr > SCRB_MAX_ADDR)
         begin
            scrub_done <= 1'b1;
            wr_valid   <= 1'b0;
         end
      end
      else if (!scrub_done)
      begin
         // First request one cycle after the enable is seen
         wr_valid <= 1'b1;
      end
   end

endmodule

//--- hdl/scrub_status_mux.sv
// ------------------------------
// Scrub status and ID outputs
// ------------------------------
`timescale 1ns/10ps

module scrub_status_mux
(
   input  logic                              clk,
   input  logic                              core_rst_n,

   input  logic                              dbg_en,
   input  logic [2:0]                        dbg_sel,

   input  logic [dram_scrub_pkg::ADDR_W-1:0] scrub_addr_a,
   input  logic [dram_scrub_pkg::ADDR_W-1:0] scrub_addr_b,
   input  logic                              scrub_done_a,
   input  logic                              scrub_done_b,

   input  logic [1:0]                        ddr_ready,

   output logic [31:0]                       id0,
   output logic [31:0]                       id1,
   output logic [31:0]                       status0
);

   import dram_scrub_pkg::*;

   logic [ADDR_W-1:0] dbg_addr;
   logic [1:0]        ddr_ready_q;

   // Only select 1 picks channel B, anything else shows channel A
   assign dbg_addr = (dbg_sel == 3'd1) ? scrub_addr_b : scrub_addr_a;

   // ------------------------------
   // ID words
   // ------------------------------
   always_ff @(posedge clk)
   begin
      id0 <= dbg_en ? dbg_addr[31:0] : CL_ID0_VAL;
      id1 <= dbg_en ? dbg_addr[ADDR_W-1:32] : CL_ID1_VAL;
   end

   // ------------------------------
   // Status word
   // ------------------------------
   // Bits 1:0 done flags, bits 5:4 sampled memory ready
   always_ff @(posedge clk or negedge core_rst_n)
   begin
      if (!core_rst_n)
      begin
         ddr_ready_q <= 2'b00;
         status0     <= 32'd0;
      end
      else
      begin
         ddr_ready_q <= ddr_ready;
         status0     <= {26'd0, ddr_ready_q, 2'b00, scrub_done_b, scrub_done_a};
      end
   end

endmodule

//--- hdl/dram_scrub_top.sv
// ------------------------------
// Two-channel DRAM scrub controller
// ------------------------------
`timescale 1ns/10ps

module dram_scrub_top
#(
   parameter logic [dram_scrub_pkg::ADDR_W-1:0] SCRB_MAX_ADDR         = 'h1FFF,
   parameter int                                SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                                  clk,
   input  logic                                  sync_rst_n,

   // APB slave
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [dram_scrub_pkg::APB_ADDR_W-1:0] paddr,
   input  logic [31:0]                           pwdata,
   output logic                                  pready,
   output logic [31:0]                           prdata,
   output logic                                  pslverr,

   input  logic                                  flr_assert,
   output logic                                  flr_done,

   // Channel A write requests
   output logic                                  wr_valid_a,
   output logic [dram_scrub_pkg::ADDR_W-1:0]     wr_addr_a,
   input  logic                                  wr_ready_a,

   // Channel B write requests
   output logic                                  wr_valid_b,
   output logic [dram_scrub_pkg::ADDR_W-1:0]     wr_addr_b,
   input  logic                                  wr_ready_b,

   input  logic [1:0]                            ddr_ready,
   output logic [31:0]                           id0,
   output logic [31:0]                           id1
);

   import dram_scrub_pkg::*;

   logic              core_rst_n;
   logic              scrub_en_a;
   logic              scrub_en_b;
   logic              dbg_en;
   logic [2:0]        dbg_sel;
   logic [31:0]       status0;
   logic [ADDR_W-1:0] scrub_addr_a;
   logic [ADDR_W-1:0] scrub_addr_b;
   logic              scrub_done_a;
   logic              scrub_done_b;

   core_rst_sync core_rst_sync_i
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .core_rst_n (core_rst_n)
   );

   scrub_cfg_regs scrub_cfg_regs_i
   (
      .clk        (clk),
      .core_rst_n (core_rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .pready     (pready),
      .prdata     (prdata),
      .pslverr    (pslverr),
      .status0    (status0),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .scrub_en_a (scrub_en_a),
      .scrub_en_b (scrub_en_b),
      .dbg_en     (dbg_en),
      .dbg_sel    (dbg_sel)
   );

   // ------------------------------
   // Scrubbers
   // ------------------------------
   ddr_scrubber
   #(
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   )
   ddr_scrubber_a_i
   (
      .clk        (clk),
      .core_rst_n (core_rst_n),
      .scrub_en   (scrub_en_a),
      .wr_ready   (wr_ready_a),
      .wr_valid   (wr_valid_a),
      .wr_addr    (wr_addr_a),
      .scrub_addr (scrub_addr_a),
      .scrub_done (scrub_done_a)
   );

   ddr_scrubber
   #(
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   )
   ddr_scrubber_b_i
   (
      .clk        (clk),
      .core_rst_n (core_rst_n),
      .scrub_en   (scrub_en_b),
      .wr_ready   (wr_ready_b),
      .wr_valid   (wr_valid_b),
      .wr_addr    (wr_addr_b),
      .scrub_addr (scrub_addr_b),
      .scrub_done (scrub_done_b)
   );

   scrub_status_mux scrub_status_mux_i
   (
      .clk          (clk),
      .core_rst_n   (core_rst_n),
      .dbg_en       (dbg_en),
      .dbg_sel      (dbg_sel),
      .scrub_addr_a (scrub_addr_a),
      .scrub_addr_b (scrub_addr_b),
      .scrub_done_a (scrub_done_a),
      .scrub_done_b (scrub_done_b),
      .ddr_ready    (ddr_ready),
      .id0          (id0),
      .id1          (id1),
      .status0      (status0)
   );

endmodule

//--- bench/tb_dram_scrub.sv
// ------------------------------
// Testbench for the DRAM scrub controller
// ------------------------------
`timescale 1ns/10ps

module tb_dram_scrub;

   import dram_scrub_pkg::*;

   localparam logic [ADDR_W-1:0] MAX_ADDR     = 64'h1FFF;
   localparam int                BURST_LEN_M1 = 15;
   localparam logic [ADDR_W-1:0] STEP_BYTES   = ADDR_W'((BURST_LEN_M1 + 1) * BEAT_BYTES);
   localparam int                APB_TIMEOUT  = 16;
   localparam int                DONE_POLLS   = 200;
   localparam int                FLR_WINDOW   = 12;

   logic                  clk;
   logic                  sync_rst_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   logic [31:0]           pwdata;
   logic                  pready;
   logic [31:0]           prdata;
   logic                  pslverr;
   logic                  flr_assert;
   logic                  flr_done;
   logic                  wr_valid_a;
   logic [ADDR_W-1:0]     wr_addr_a;
   logic                  wr_ready_a;
   logic                  wr_valid_b;
   logic [ADDR_W-1:0]     wr_addr_b;
   logic                  wr_ready_b;
   logic [1:0]            ddr_ready;
   logic [31:0]           id0;
   logic [31:0]           id1;

   integer seed = 32'h5f778f00;
   integer rnd;

   // Accepted request counters, owned by the compare process
   int accepted_a = 0;
   int accepted_b = 0;
   // Counter values at the start of the current scrub pass
   int start_a = 0;
   int start_b = 0;

   dram_scrub_top
   #(
      .SCRB_MAX_ADDR         (MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (BURST_LEN_M1)
   )
   dram_scrub_top_i
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .pready     (pready),
      .prdata     (prdata),
      .pslverr    (pslverr),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .wr_valid_a (wr_valid_a),
      .wr_addr_a  (wr_addr_a),
      .wr_ready_a (wr_ready_a),
      .wr_valid_b (wr_valid_b),
      .wr_addr_b  (wr_addr_b),
      .wr_ready_b (wr_ready_b),
      .ddr_ready  (ddr_ready),
      .id0        (id0),
      .id1        (id1)
   );

   always #4 clk = ~clk;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic [ADDR_W-1:0] expected_addr(input int idx);
      expected_addr = ADDR_W'(idx) * STEP_BYTES;
   endfunction

   // Number of bursts whose start address is within range
   function automatic int expected_count();
      logic [ADDR_W-1:0] addr;
      int                n;
      addr = '0;
      n    = 0;
      while (addr <= MAX_ADDR)
      begin
         n++;
         addr = addr + STEP_BYTES;
      end
      expected_count = n;
   endfunction

   function automatic logic [31:0] expected_id(input logic dbg, input logic [2:0] sel,
                                               input logic [ADDR_W-1:0] addr_a,
                                               input logic [ADDR_W-1:0] addr_b,
                                               input logic upper);
      logic [ADDR_W-1:0] addr;
      addr = (sel == 3'd1) ? addr_b : addr_a;
      if (!dbg)
         expected_id = upper ? CL_ID1_VAL : CL_ID0_VAL;
      else
         expected_id = upper ? addr[63:32] : addr[31:0];
   endfunction

   function automatic logic [31:0] expected_status(input logic done_a, input logic done_b,
                                                   input logic [1:0] rdy);
      expected_status      = 32'd0;
      expected_status[0]   = done_a;
      expected_status[1]   = done_b;
      expected_status[5:4] = rdy;
   endfunction

   function automatic logic [31:0] ctl_word(input logic en_a, input logic en_b,
                                            input logic dbg, input logic [2:0] sel);
      ctl_word                             = 32'd0;
      ctl_word[CTL_EN_A_BIT]               = en_a;
      ctl_word[CTL_EN_B_BIT]               = en_b;
      ctl_word[CTL_DBG_EN_BIT]             = dbg;
      ctl_word[CTL_DBG_SEL_LSB +: 3]       = sel;
   endfunction

   // ------------------------------
   // Checks and bus tasks
   // ------------------------------
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic run_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int waited;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!pready)
      begin
         waited++;
         if (waited > APB_TIMEOUT)
            fail_run("APB transfer never saw pready");
         @(negedge clk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_transfer(1'b1, addr, data, rd, err);
      check_value("pslverr", 64'(err), 64'd0);
   endtask

   task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
      logic err;
      apb_transfer(1'b0, addr, 32'd0, data, err);
      check_value("pslverr", 64'(err), 64'd0);
   endtask

   task automatic wait_scrub_done(input logic [1:0] mask);
      logic [31:0] st;
      int          polls;
      polls = 0;
      read_reg(REG_STATUS0, st);
      while ((st[1:0] & mask) != mask)
      begin
         polls++;
         if (polls > DONE_POLLS)
            fail_run("Scrub did not finish within the poll limit");
         read_reg(REG_STATUS0, st);
      end
   endtask

   // ID outputs trail the control word by one register stage
   task automatic check_ids(input logic dbg, input logic [2:0] sel,
                            input logic [ADDR_W-1:0] addr_a,
                            input logic [ADDR_W-1:0] addr_b);
      run_cycles(2);
      @(negedge clk);
      check_value("id0", 64'(id0), 64'(expected_id(dbg, sel, addr_a, addr_b, 1'b0)));
      check_value("id1", 64'(id1), 64'(expected_id(dbg, sel, addr_a, addr_b, 1'b1)));
   endtask

   // ------------------------------
   // Back-pressure and compare
   // ------------------------------
   always @(posedge clk)
   begin
      rnd = $random(seed);
      wr_ready_a <= rnd[0];
      wr_ready_b <= rnd[5];
   end

   // Handshake values are stable during the low clock phase
   always @(negedge clk)
   begin
      if (sync_rst_n && wr_valid_a && wr_ready_a)
      begin
         if (accepted_a - start_a >= expected_count())
            fail_run("Channel A issued more requests than expected");
         check_value("wr_addr_a", wr_addr_a, expected_addr(accepted_a - start_a));
         accepted_a = accepted_a + 1;
      end
      if (sync_rst_n && wr_valid_b && wr_ready_b)
      begin
         if (accepted_b - start_b >= expected_count())
            fail_run("Channel B issued more requests than expected");
         check_value("wr_addr_b", wr_addr_b, expected_addr(accepted_b - start_b));
         accepted_b = accepted_b + 1;
      end
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial
   begin
      logic [31:0]       rd;
      logic              err;
      int                prev_a;
      int                pulses;
      logic [ADDR_W-1:0] fin_a;

      clk        = 1'b0;
      sync_rst_n <= 1'b0;
      psel       <= 1'b0;
      penable    <= 1'b0;
      pwrite     <= 1'b0;
      paddr      <= '0;
      pwdata     <= 32'd0;
      flr_assert <= 1'b0;
      wr_ready_a <= 1'b0;
      wr_ready_b <= 1'b0;
      ddr_ready  <= 2'b00;

      run_cycles(10);
      sync_rst_n <= 1'b1;
      // Internal reset releases six edges later
      run_cycles(8);

      // Reset state
      @(negedge clk);
      check_value("pready", 64'(pready), 64'd0);
      check_value("pslverr", 64'(pslverr), 64'd0);
      check_value("flr_done", 64'(flr_done), 64'd0);
      check_value("wr_valid_a", 64'(wr_valid_a), 64'd0);
      check_value("wr_valid_b", 64'(wr_valid_b), 64'd0);
      check_value("id0", 64'(id0), 64'(CL_ID0_VAL));
      check_value("id1", 64'(id1), 64'(CL_ID1_VAL));
      read_reg(REG_CTL0, rd);
      check_value("ctl0", 64'(rd), 64'd0);
      apb_transfer(1'b0, 8'h08, 32'd0, rd, err);
      check_value("pslverr", 64'(err), 64'd1);
      check_value("prdata", 64'(rd), 64'd0);

      // Channel A alone
      start_a = accepted_a;
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b0, 3'd0));
      wait_scrub_done(2'b01);
      check_value("channel A requests", 64'(accepted_a - start_a), 64'(expected_count()));
      read_reg(REG_STATUS0, rd);
      check_value("status0", 64'(rd), 64'(expected_status(1'b1, 1'b0, 2'b00)));

      // Channel B next to A
      ddr_ready <= 2'b10;
      prev_a  = accepted_a;
      start_b = accepted_b;
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b1, 1'b0, 3'd0));
      wait_scrub_done(2'b11);
      check_value("channel B requests", 64'(accepted_b - start_b), 64'(expected_count()));
      check_value("channel A requests", 64'(accepted_a), 64'(prev_a));
      read_reg(REG_STATUS0, rd);
      check_value("status0", 64'(rd), 64'(expected_status(1'b1, 1'b1, 2'b10)));

      // Debug readout with channel B rearmed to address 0
      // Select 3 falls back to channel A
      fin_a = expected_addr(expected_count());
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b0, 3'd0));
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b1, 3'd0));
      check_ids(1'b1, 3'd0, fin_a, 64'd0);
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b1, 3'd1));
      check_ids(1'b1, 3'd1, fin_a, 64'd0);
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b1, 3'd3));
      check_ids(1'b1, 3'd3, fin_a, 64'd0);
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b0, 3'd0));
      check_ids(1'b0, 3'd0, fin_a, 64'd0);

      // Rearm channel A
      write_reg(REG_CTL0, ctl_word(1'b0, 1'b0, 1'b0, 3'd0));
      run_cycles(3);
      read_reg(REG_STATUS0, rd);
      check_value("status0", 64'(rd), 64'(expected_status(1'b0, 1'b0, 2'b10)));
      @(negedge clk);
      check_value("wr_valid_a", 64'(wr_valid_a), 64'd0);
      start_a = accepted_a;
      write_reg(REG_CTL0, ctl_word(1'b1, 1'b0, 1'b0, 3'd0));
      wait_scrub_done(2'b01);
      check_value("channel A requests", 64'(accepted_a - start_a), 64'(expected_count()));

      // FLR acknowledge, one request cycle
      @(posedge clk);
      flr_assert <= 1'b1;
      @(posedge clk);
      flr_assert <= 1'b0;
      pulses = 0;
      for (int i = 0; i < FLR_WINDOW; i++)
      begin
         @(negedge clk);
         if (flr_done)
            pulses++;
      end
      if (pulses == 0)
         fail_run("No flr_done pulse within the window");
      check_value("flr_done high cycles", 64'(pulses), 64'd1);

      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- sources.f
hdl/dram_scrub_pkg.sv
hdl/core_rst_sync.sv
hdl/scrub_cfg_regs.sv
hdl/ddr_scrubber.sv
hdl/scrub_status_mux.sv
hdl/dram_scrub_top.sv
bench/tb_dram_scrub.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DRAM scrub testbench with Verilator
# Exit status is zero only when the simulation passes
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
   --top-module tb_dram_scrub -f sources.f \
   -Mdir obj_dir -o tb_dram_scrub \
   && ./obj_dir/tb_dram_scrub \
   || { echo "simulation run failed"; exit 1; }
